/* include/ring_defines.svh */
// Ring memory subsystem constants
// Address windows of the two RAM bridges and the RAM depth

`ifndef RING_DEFINES_SVH
`define RING_DEFINES_SVH

// Address bits that every bridge compares against its base
// The low 16 bits select a location inside a window
`define RING_ADDR_MASK 32'hFFFF_0000

// Window base of the first bridge on the ring
`define RING_BASE0 32'h0001_0000

// Window base of the second bridge on the ring
`define RING_BASE1 32'h0002_0000

// Width of the word index into each private RAM
// Eight bits give 256 words of 32 bits per bridge
`define RAM_INDEX_BITS 8

`endif

/* rtl/ring_bus_pkg.sv */
// Ring bus types
// Packet layout on the ring and the host command and response records

package ring_bus_pkg;

  // Byte address as carried on the ring and from the host
  typedef logic [31:0] addr_t;

  // One data word, write data going out and read data coming back
  typedef logic [31:0] data_t;

  // Byte enables, bit 0 covers bits 7:0 of the data word
  typedef logic [3:0] mask_t;

  // Transaction tag stamped by the master on every packet
  typedef logic [7:0] tag_t;

  // Ring packet of 79 bits
  // Field order matches the legacy flat layout with valid in bit 78
  // and the address in bits 31:0
  typedef struct packed {
    logic  valid;
    logic  write;
    logic  ack;
    tag_t  tag;
    mask_t mask;
    data_t data;
    addr_t addr;
  } ring_pkt_t;

  // Host command of 69 bits, presented for one cycle with cmd_stb
  typedef struct packed {
    logic  write;
    addr_t addr;
    mask_t mask;
    data_t data;
  } host_cmd_t;

  // Host response of 74 bits, presented for one cycle with rsp_stb
  // A clear ack means that no bridge claimed the address
  // The data field holds the word read from RAM, which for a write
  // is the value the word had before it was written
  typedef struct packed {
    logic  write;
    logic  ack;
    tag_t  tag;
    addr_t addr;
    data_t data;
  } host_rsp_t;

endpackage

/* rtl/ram_port_pkg.sv */
// RAM port types
// Request record from a bridge to its private RAM and the word formats

`include "ring_defines.svh"

package ram_port_pkg;

  // Word index into a RAM, the byte address divided by four
  typedef logic [`RAM_INDEX_BITS-1:0] ram_index_t;

  // One RAM word
  typedef logic [31:0] ram_word_t;

  // Byte lane write enables of a RAM word
  typedef logic [3:0] ram_mask_t;

  // Request from a bridge to its RAM
  // The RAM acts on it in the same cycle that cs is high
  typedef struct packed {
    logic       cs;
    logic       we;
    ram_index_t index;
    ram_mask_t  mask;
    ram_word_t  wdata;
  } ram_req_t;

endpackage

/* rtl/byte_ram.sv */
// Single port RAM with byte lane write enables
// Read data is registered and appears one cycle after chip select

`timescale 1ns/10ps
`include "ring_defines.svh"

module byte_ram (
  input  logic                    CLK,
  input  logic                    RST,
  input  ram_port_pkg::ram_req_t  req,
  output ram_port_pkg::ram_word_t rdata
);
  import ram_port_pkg::*;

  localparam int DEPTH = 1 << `RAM_INDEX_BITS;
  // One write enable per byte of the word
  localparam int LANES = $bits(ram_mask_t);

  // Storage array, its contents are undefined after power up
  ram_word_t mem [DEPTH];

  // Byte lane writes
  // Lanes whose mask bit is clear keep their previous contents
  always_ff @(posedge CLK)
  begin
    if (req.cs && req.we)
    begin
      for (int lane = 0; lane < LANES; lane++)
      begin
        if (req.mask[lane])
        begin
          mem[req.index][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
        end
      end
    end
  end

  // Registered read on every access
  // On a write this captures the word as it was before the update,
  // since the array write above lands at the same edge
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      rdata <= '0;
    end
    else if (req.cs)
    begin
      rdata <= mem[req.index];
    end
  end

endmodule

/* rtl/ring_ram_bridge.sv */
// Ring to RAM bridge
// Claims packets inside its address window and turns them into RAM accesses

`timescale 1ns/10ps
`include "ring_defines.svh"

module ring_ram_bridge #(
  parameter ring_bus_pkg::addr_t ADDR_BASE = `RING_BASE0
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  ring_bus_pkg::ring_pkt_t ring_in,
  output ring_bus_pkg::ring_pkt_t ring_out,
  output ram_port_pkg::ram_req_t  ram_req,
  input  ram_port_pkg::ram_word_t ram_rdata
);
  import ring_bus_pkg::*;
  import ram_port_pkg::*;

  // Only the masked address bits take part in the window compare
  localparam addr_t WIN_MASK = `RING_ADDR_MASK;
  localparam addr_t WIN_BASE = ADDR_BASE & WIN_MASK;

  // First stage holds the packet while the RAM is accessed
  ring_pkt_t pkt_s1;
  // Second stage lines up with the RAM read data
  ring_pkt_t pkt_s2;
  // Packet as it will leave on the ring
  ring_pkt_t pkt_merged;
  ring_pkt_t pkt_out;

  logic       match_s1;
  logic       match_s2;
  ram_index_t word_index;

  // A packet is ours when it is valid and falls inside the window
  assign match_s1 = pkt_s1.valid && ((pkt_s1.addr & WIN_MASK) == WIN_BASE);

  // Bits 1:0 select a byte and are covered by the mask instead
  assign word_index = pkt_s1.addr[`RAM_INDEX_BITS+1:2];

  // The RAM request comes straight off the first stage register
  // so the read data is ready exactly when the packet reaches stage two
  always_comb
  begin
    ram_req.cs    = match_s1;
    ram_req.we    = pkt_s1.write;
    ram_req.index = word_index;
    ram_req.mask  = pkt_s1.mask;
    ram_req.wdata = pkt_s1.data;
  end

  // A claimed packet returns with ack set and the RAM word in its data
  // Anything else, including empty slots, passes through untouched
  always_comb
  begin
    pkt_merged = pkt_s2;
    if (match_s2)
    begin
      pkt_merged.ack  = 1'b1;
      pkt_merged.data = ram_rdata;
    end
  end

  // Three register stages from ring_in to ring_out
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pkt_s1   <= '0;
      pkt_s2   <= '0;
      match_s2 <= 1'b0;
      pkt_out  <= '0;
    end
    else
    begin
      pkt_s1   <= ring_in;
      pkt_s2   <= pkt_s1;
      match_s2 <= match_s1;
      pkt_out  <= pkt_merged;
    end
  end

  // Each node drives the next link only from its own register
  assign ring_out = pkt_out;

endmodule

/* rtl/ring_master.sv */
// Ring master
// Turns host commands into tagged ring packets and returning packets into responses

`timescale 1ns/10ps

module ring_master (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    cmd_stb,
  input  ring_bus_pkg::host_cmd_t cmd,
  output logic                    rsp_stb,
  output ring_bus_pkg::host_rsp_t rsp,
  output ring_bus_pkg::ring_pkt_t ring_out,
  input  ring_bus_pkg::ring_pkt_t ring_in
);
  import ring_bus_pkg::*;

  // Tag for the next accepted command, wraps after 255
  tag_t tag_cnt;

  // Packet to be launched at the next edge
  ring_pkt_t pkt_next;
  // Response built from the packet now arriving on ring_in
  host_rsp_t rsp_next;

  // The master is the only source of packets on the ring
  // Every packet that comes back is retired here, so the slot it
  // leaves behind is always empty and a command can go out every cycle
  always_comb
  begin
    pkt_next = '0;
    if (cmd_stb)
    begin
      pkt_next.valid = 1'b1;
      pkt_next.write = cmd.write;
      // Bridges set ack when they claim the address
      pkt_next.ack   = 1'b0;
      pkt_next.tag   = tag_cnt;
      pkt_next.mask  = cmd.mask;
      pkt_next.data  = cmd.data;
      pkt_next.addr  = cmd.addr;
    end
  end

  // Returning fields go to the host as they are
  // An unclaimed packet still carries the data it was sent with
  always_comb
  begin
    rsp_next.write = ring_in.write;
    rsp_next.ack   = ring_in.ack;
    rsp_next.tag   = ring_in.tag;
    rsp_next.addr  = ring_in.addr;
    rsp_next.data  = ring_in.data;
  end

  // Launch side with the tag counter
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      ring_out <= '0;
      tag_cnt  <= '0;
    end
    else
    begin
      ring_out <= pkt_next;
      if (cmd_stb)
      begin
        tag_cnt <= tag_cnt + tag_t'(1);
      end
    end
  end

  // Retire side
  // The strobe follows the valid bit of the incoming slot
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      rsp_stb <= 1'b0;
      rsp     <= '0;
    end
    else
    begin
      rsp_stb <= ring_in.valid;
      if (ring_in.valid)
      begin
        rsp <= rsp_next;
      end
    end
  end

endmodule

/* rtl/ring_mem_top.sv */
// Ring memory subsystem top
// One master and two RAM bridges on a closed ring, each bridge with its own RAM

`timescale 1ns/10ps
`include "ring_defines.svh"

module ring_mem_top (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    cmd_stb,
  input  ring_bus_pkg::host_cmd_t cmd,
  output logic                    rsp_stb,
  output ring_bus_pkg::host_rsp_t rsp
);
  import ring_bus_pkg::*;
  import ram_port_pkg::*;

  // Ring links in the direction of travel
  ring_pkt_t ring_m_to_b0;
  ring_pkt_t ring_b0_to_b1;
  ring_pkt_t ring_b1_to_m;

  // RAM ports of the two bridges
  ram_req_t  ram_req0;
  ram_req_t  ram_req1;
  ram_word_t ram_rdata0;
  ram_word_t ram_rdata1;

  // Host side of the ring
  ring_master u_master (
    .CLK      (CLK),
    .RST      (RST),
    .cmd_stb  (cmd_stb),
    .cmd      (cmd),
    .rsp_stb  (rsp_stb),
    .rsp      (rsp),
    .ring_out (ring_m_to_b0),
    .ring_in  (ring_b1_to_m)
  );

  // First node, claims the window at RING_BASE0
  ring_ram_bridge #(
    .ADDR_BASE (`RING_BASE0)
  ) u_bridge0 (
    .CLK       (CLK),
    .RST       (RST),
    .ring_in   (ring_m_to_b0),
    .ring_out  (ring_b0_to_b1),
    .ram_req   (ram_req0),
    .ram_rdata (ram_rdata0)
  );

  byte_ram u_ram0 (
    .CLK   (CLK),
    .RST   (RST),
    .req   (ram_req0),
    .rdata (ram_rdata0)
  );

  // Second node closes the ring back to the master
  ring_ram_bridge #(
    .ADDR_BASE (`RING_BASE1)
  ) u_bridge1 (
    .CLK       (CLK),
    .RST       (RST),
    .ring_in   (ring_b0_to_b1),
    .ring_out  (ring_b1_to_m),
    .ram_req   (ram_req1),
    .ram_rdata (ram_rdata1)
  );

  byte_ram u_ram1 (
    .CLK   (CLK),
    .RST   (RST),
    .req   (ram_req1),
    .rdata (ram_rdata1)
  );

endmodule

/* testbench/tb_ring_mem_top.sv */
// Testbench for the ring memory subsystem
// Applies a command table to the host port and checks every response

`timescale 1ns/10ps
`include "ring_defines.svh"

module tb_ring_mem_top;
  import ring_bus_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  // Cycles from the command strobe to its response strobe
  localparam int RSP_LATENCY  = 8;
  // Long enough for the 8-bit tag to wrap
  localparam int STREAM_LEN   = 260;
  localparam addr_t WIN0  = `RING_BASE0;
  localparam addr_t WIN1  = `RING_BASE1;
  // No bridge claims this window
  localparam addr_t NOWIN = 32'h0003_0000;

  // One table row with its expected response
  // chk_data is clear where the old RAM word is not known yet
  typedef struct packed {
    logic  write;
    addr_t addr;
    mask_t mask;
    data_t data;
    logic  exp_ack;
    logic  chk_data;
    data_t exp_data;
    logic  idle_gap;
  } entry_t;

  // Response that an issued command is waiting for
  typedef struct packed {
    logic  write;
    logic  ack;
    tag_t  tag;
    addr_t addr;
    logic  chk_data;
    data_t data;
    int    issue_cycle;
  } expect_t;

  logic      CLK;
  logic      RST;
  logic      cmd_stb;
  host_cmd_t cmd;
  logic      rsp_stb;
  host_rsp_t rsp;

  entry_t  cmd_table[$];
  expect_t exp_q[$];
  tag_t    next_tag;
  logic    table_ready;
  int      cycle_cnt = 0;

  ring_mem_top u_ring_mem_top (
    .CLK     (CLK),
    .RST     (RST),
    .cmd_stb (cmd_stb),
    .cmd     (cmd),
    .rsp_stb (rsp_stb),
    .rsp     (rsp)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Rising edge count, used to time each response against its command
  always @(posedge CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_run(input string reason);
    $display("Error at %0t: %s", $time, reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, expected);
    $display("*** FAILED ***");
    $fatal(1, "value mismatch");
  endtask

  task automatic add_entry(input logic write, input addr_t addr, input mask_t mask,
                           input data_t data, input logic exp_ack, input logic chk_data,
                           input data_t exp_data, input logic idle_gap);
    entry_t e;
    e = '{write, addr, mask, data, exp_ack, chk_data, exp_data, idle_gap};
    cmd_table.push_back(e);
  endtask

  // Expected words follow the byte-lane merge rule by hand
  // A write returns the word as it was before the write
  task automatic build_table();
    int    i;
    addr_t a;
    data_t d;
    // Full word write and read back in window 0
    add_entry(1'b1, WIN0 + 32'h000, 4'hF, 32'hA5A5_1234, 1'b1, 1'b0, 32'h0, 1'b0);
    add_entry(1'b0, WIN0 + 32'h000, 4'hF, 32'h0, 1'b1, 1'b1, 32'hA5A5_1234, 1'b0);
    // Partial writes on one word, each response shows the previous word
    add_entry(1'b1, WIN0 + 32'h004, 4'hF, 32'h1122_3344, 1'b1, 1'b0, 32'h0, 1'b1);
    add_entry(1'b1, WIN0 + 32'h004, 4'b0001, 32'hFFFF_FFAA, 1'b1, 1'b1, 32'h1122_3344, 1'b0);
    add_entry(1'b1, WIN0 + 32'h004, 4'b0100, 32'h00BB_0000, 1'b1, 1'b1, 32'h1122_33AA, 1'b1);
    add_entry(1'b0, WIN0 + 32'h004, 4'hF, 32'h0, 1'b1, 1'b1, 32'h11BB_33AA, 1'b0);
    add_entry(1'b1, WIN0 + 32'h004, 4'b1010, 32'hCC00_DD00, 1'b1, 1'b1, 32'h11BB_33AA, 1'b0);
    add_entry(1'b0, WIN0 + 32'h004, 4'hF, 32'h0, 1'b1, 1'b1, 32'hCCBB_DDAA, 1'b1);
    // Same offset in both windows holds separate words
    add_entry(1'b1, WIN0 + 32'h040, 4'hF, 32'h0000_0040, 1'b1, 1'b0, 32'h0, 1'b0);
    add_entry(1'b1, WIN1 + 32'h040, 4'hF, 32'h1111_0040, 1'b1, 1'b0, 32'h0, 1'b1);
    add_entry(1'b0, WIN0 + 32'h040, 4'hF, 32'h0, 1'b1, 1'b1, 32'h0000_0040, 1'b0);
    add_entry(1'b0, WIN1 + 32'h040, 4'hF, 32'h0, 1'b1, 1'b1, 32'h1111_0040, 1'b1);
    // Empty mask leaves the word alone
    add_entry(1'b1, WIN1 + 32'h040, 4'h0, 32'hDEAD_BEEF, 1'b1, 1'b1, 32'h1111_0040, 1'b0);
    add_entry(1'b0, WIN1 + 32'h040, 4'hF, 32'h0, 1'b1, 1'b1, 32'h1111_0040, 1'b1);
    // Top word of window 1
    add_entry(1'b1, WIN1 + 32'h3FC, 4'hF, 32'hCAFE_F00D, 1'b1, 1'b0, 32'h0, 1'b0);
    add_entry(1'b0, WIN1 + 32'h3FC, 4'hF, 32'h0, 1'b1, 1'b1, 32'hCAFE_F00D, 1'b1);
    // Unclaimed packets come back with ack clear and their own data
    add_entry(1'b1, NOWIN + 32'h040, 4'hF, 32'h5555_AAAA, 1'b0, 1'b1, 32'h5555_AAAA, 1'b0);
    add_entry(1'b0, 32'h0000_0010, 4'hF, 32'h0BAD_F00D, 1'b0, 1'b1, 32'h0BAD_F00D, 1'b1);
    add_entry(1'b0, 32'hFFFF_FFFC, 4'hF, 32'h0, 1'b0, 1'b1, 32'h0, 1'b0);
    // Back to back stream mixing claimed reads and unclaimed writes
    for (i = 0; i < STREAM_LEN; i++)
    begin
      if (i[0] == 1'b0)
      begin
        add_entry(1'b0, WIN0, 4'hF, 32'h0, 1'b1, 1'b1, 32'hA5A5_1234, 1'b0);
      end
      else
      begin
        a = NOWIN + {i[29:0], 2'b00};
        d = {16'h5EED, i[15:0]};
        add_entry(1'b1, a, 4'hF, d, 1'b0, 1'b1, d, 1'b0);
      end
    end
  endtask

  // Drives one command for a cycle and records what should come back
  task automatic issue_command(input entry_t e);
    expect_t x;
    cmd.write = e.write;
    cmd.addr  = e.addr;
    cmd.mask  = e.mask;
    cmd.data  = e.data;
    cmd_stb   = 1'b1;
    x = '{e.write, e.exp_ack, next_tag, e.addr, e.chk_data, e.exp_data, cycle_cnt};
    exp_q.push_back(x);
    next_tag = next_tag + tag_t'(1);
  endtask

  // Response checker, outputs are settled by the falling edge
  always @(negedge CLK)
  begin
    expect_t x;
    int      latency;
    if (RST)
    begin
      assert (rsp_stb == 1'b0)
      else report_mismatch("rsp_stb", {31'h0, rsp_stb}, 32'h0);
    end
    else if (rsp_stb)
    begin
      assert (exp_q.size() > 0)
      else stop_run("response strobe with no command outstanding");
      x = exp_q.pop_front();
      latency = cycle_cnt - x.issue_cycle;
      assert (latency == RSP_LATENCY)
      else report_mismatch("response latency", latency, RSP_LATENCY);
      assert (rsp.tag == x.tag)
      else report_mismatch("rsp.tag", {24'h0, rsp.tag}, {24'h0, x.tag});
      assert (rsp.write == x.write)
      else report_mismatch("rsp.write", {31'h0, rsp.write}, {31'h0, x.write});
      assert (rsp.ack == x.ack)
      else report_mismatch("rsp.ack", {31'h0, rsp.ack}, {31'h0, x.ack});
      assert (rsp.addr == x.addr)
      else report_mismatch("rsp.addr", rsp.addr, x.addr);
      if (x.chk_data)
      begin
        assert (rsp.data == x.data)
        else report_mismatch("rsp.data", rsp.data, x.data);
      end
    end
  end

  // Stimulus
  initial
  begin
    int gap;
    void'($urandom(65));
    CLK         = 1'b0;
    RST         = 1'b1;
    cmd_stb     = 1'b0;
    cmd         = '0;
    next_tag    = '0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    for (int i = 0; i < cmd_table.size(); i++)
    begin
      @(negedge CLK);
      issue_command(cmd_table[i]);
      // Rows marked for a gap are followed by 0 to 3 idle cycles
      if (cmd_table[i].idle_gap)
      begin
        gap = $urandom % 4;
        repeat (gap)
        begin
          @(negedge CLK);
          cmd_stb = 1'b0;
        end
      end
    end
    @(negedge CLK);
    cmd_stb = 1'b0;
    // Every response is due a fixed 8 cycles after its command
    // The two extra cycles catch a stray strobe
    repeat (RSP_LATENCY + 2) @(negedge CLK);
    if (exp_q.size() == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      stop_run("responses still outstanding at the end of the run");
    end
  end

  // Watchdog sized from the table length
  initial
  begin
    wait (table_ready);
    repeat (cmd_table.size() * 4 + 40) @(posedge CLK);
    stop_run("watchdog timeout, responses did not drain in time");
  end

endmodule

/* ring_mem.f */
+incdir+include
rtl/ring_bus_pkg.sv
rtl/ram_port_pkg.sv
rtl/byte_ram.sv
rtl/ring_ram_bridge.sv
rtl/ring_master.sv
rtl/ring_mem_top.sv
testbench/tb_ring_mem_top.sv

/* Makefile */
# Verilator build and run of the ring memory testbench

TOP := tb_ring_mem_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f ring_mem.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
